//--- design/eth_bridge_pkg.sv
/*
 * Shared widths, sizes and beat types for the Ethernet to serial link bridge.
 * Imported by wildcard into every RTL module and the testbench.
 */
package eth_bridge_pkg;

    // ------------------------------
    // sizes
    // ------------------------------
    localparam int ETH_COUNT  = 4;   // MAC ports on the board
    localparam int PORT_W     = 2;   // width of eth_sel
    localparam int BYTE_W     = 8;
    localparam int CUT_BYTES  = 8;   // preamble + SFD stripped on receive
    localparam int FIFO_DEPTH = 64;
    localparam int FIFO_AW    = 6;   // log2 of FIFO_DEPTH

    // ------------------------------
    // types
    // ------------------------------
    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [PORT_W-1:0] port_t;

    // MAC receive payload heading out on the link
    typedef struct packed {
        logic  last;
        byte_t data;
    } rx_beat_t;

    // link receive payload heading to a MAC
    // same layout, separate type so the two FIFO roles never mix
    typedef struct packed {
        logic  last;
        byte_t data;
    } tx_beat_t;

endpackage

//--- design/rx_payload_cut.sv
`timescale 1ns/1ps
/*
 * Drops the first CUT_BYTES bytes of each received MAC frame and marks the payload.
 * Output is registered, one clock behind the input strobes.
 */
module rx_payload_cut
    import eth_bridge_pkg::*;
(
    input  logic     clk125M,
    input  logic     rst_n_i,
    input  byte_t    rx_data_i,
    input  logic     rx_den_i,
    input  logic     rx_sof_i,
    input  logic     rx_eof_i,
    output rx_beat_t cut_beat_o,
    output logic     cut_valid_o,
    output logic     cut_sof_o
);

    logic [$clog2(CUT_BYTES + 2)-1:0] idx_q;     // stops at CUT_BYTES + 1
    logic [$clog2(CUT_BYTES + 2)-1:0] cur_idx;   // index of the beat on the input now
    logic                             in_frame_q;
    logic                             take;

    assign cur_idx = rx_sof_i ? '0 : idx_q;     // sof beat is index 0
    assign take    = rx_den_i && (rx_sof_i || in_frame_q);

    // byte index within the frame
    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            idx_q      <= '0;
            in_frame_q <= 1'b0;
        end else if (take) begin
            in_frame_q <= !rx_eof_i;
            if (cur_idx <= CUT_BYTES) begin
                idx_q <= cur_idx + 1'b1;
            end else begin
                idx_q <= cur_idx;
            end
        end
    end

    // ------------------------------
    // output stage
    // ------------------------------
    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cut_valid_o <= 1'b0;
            cut_sof_o   <= 1'b0;
        end else begin
            cut_valid_o <= take && (cur_idx >= CUT_BYTES);
            cut_sof_o   <= take && (cur_idx == CUT_BYTES);   // first payload byte
        end
    end

    always_ff @(posedge clk125M) begin
        cut_beat_o <= '{last: rx_eof_i, data: rx_data_i};
    end

endmodule

//--- design/frame_fifo.sv
`timescale 1ns/1ps
/*
 * Single-clock show-ahead FIFO with flush, used for both directions of each port.
 * The head entry is visible on rd_beat_o before it is popped.
 */
module frame_fifo
    import eth_bridge_pkg::*;
#(
    parameter type beat_t = rx_beat_t
) (
    input  logic  clk125M,
    input  logic  rst_n_i,
    input  logic  flush_i,
    input  logic  wr_i,
    input  beat_t wr_beat_i,
    input  logic  pop_i,
    output beat_t rd_beat_o,
    output logic  empty_o
);

    beat_t              mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr_q;
    logic [FIFO_AW-1:0] rd_ptr_q;
    logic [FIFO_AW:0]   count_q;      // one bit wider to tell full from empty
    logic               full;
    logic               do_wr;
    logic               do_rd;

    assign full    = (count_q == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign empty_o = (count_q == '0);

    assign do_wr = wr_i && !full && !flush_i;       // full writes are dropped
    assign do_rd = pop_i && !empty_o && !flush_i;

    // ------------------------------
    // pointers and fill level
    // ------------------------------
    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps at FIFO_DEPTH
            end
            if (do_rd) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;   // none, or both at once
            endcase
        end
    end

    // storage
    always_ff @(posedge clk125M) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= wr_beat_i;
        end
    end

    assign rd_beat_o = mem[rd_ptr_q];   // show-ahead head

endmodule

//--- design/link_port_select.sv
`timescale 1ns/1ps
/*
 * Picks the one port that talks to the serial link and decides per-port flush.
 * Routes that port's receive FIFO head to the link and link bytes to its transmit FIFO.
 */
module link_port_select
    import eth_bridge_pkg::*;
(
    input  logic                 clk125M,
    input  logic                 rst_n_i,
    input  logic                 module_en_i,
    input  port_t                eth_sel_i,
    input  logic [ETH_COUNT-1:0] mac_link_i,
    input  logic                 link_up_i,
    input  rx_beat_t             rx_beat_i [ETH_COUNT],
    input  logic [ETH_COUNT-1:0] rx_empty_i,
    input  byte_t                link_rx_data_i,
    input  logic                 link_rx_valid_i,
    input  logic                 link_rx_last_i,
    input  logic                 link_tx_ready_i,
    output logic [ETH_COUNT-1:0] flush_o,
    output logic [ETH_COUNT-1:0] rx_pop_o,
    output logic [ETH_COUNT-1:0] tx_wr_o,
    output tx_beat_t             tx_beat_o,
    output byte_t                link_tx_data_o,
    output logic                 link_tx_valid_o,
    output logic                 link_tx_last_o
);

    logic [ETH_COUNT-1:0] port_en;
    logic [ETH_COUNT-1:0] flush_d;
    logic [ETH_COUNT-1:0] flush_q;
    logic [ETH_COUNT-1:0] active;     // selected, links up, not flushing
    logic [ETH_COUNT-1:0] rx_avail;

    // ------------------------------
    // enables and flush
    // ------------------------------
    always_comb begin
        for (int x = 0; x < ETH_COUNT; x++) begin
            port_en[x] = module_en_i && (eth_sel_i == port_t'(x));
            flush_d[x] = !port_en[x] || !mac_link_i[x] || !link_up_i;
        end
    end

    // flush asserts at once but releases a clock late,
    // so a reselected port always gets one full cycle of clearing
    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            flush_q <= '1;
        end else begin
            flush_q <= flush_d;
        end
    end

    assign flush_o = flush_d | flush_q;
    assign active  = ~flush_o;

    // ------------------------------
    // toward the link
    // ------------------------------
    assign rx_avail        = active & ~rx_empty_i;   // at most one bit set
    assign link_tx_valid_o = |rx_avail;
    assign link_tx_data_o  = rx_beat_i[eth_sel_i].data;
    assign link_tx_last_o  = rx_beat_i[eth_sel_i].last;
    assign rx_pop_o        = rx_avail & {ETH_COUNT{link_tx_ready_i}};

    // from the link, no back-pressure
    assign tx_beat_o = '{last: link_rx_last_i, data: link_rx_data_i};
    assign tx_wr_o   = active & {ETH_COUNT{link_rx_valid_i}};

endmodule

//--- design/mac_tx_sequencer.sv
`timescale 1ns/1ps
/*
 * Sends one buffered frame at a time to a MAC: request, wait for ack, then stream.
 * MAC-side outputs are registered one clock after each FIFO pop.
 */
module mac_tx_sequencer
    import eth_bridge_pkg::*;
(
    input  logic     clk125M,
    input  logic     rst_n_i,
    input  tx_beat_t fifo_beat_i,
    input  logic     fifo_empty_i,
    input  logic     mac_tx_ack_i,
    output logic     fifo_pop_o,
    output logic     mac_tx_req_o,
    output byte_t    mac_tx_data_o,
    output logic     mac_tx_valid_o,
    output logic     mac_tx_sof_o,
    output logic     mac_tx_eof_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_SEND
    } state_t;

    state_t state_q;
    logic   first_q;    // next pop is the frame's first byte

    // popping starts on the ack cycle itself
    assign fifo_pop_o = !fifo_empty_i &&
                        ((state_q == ST_REQ && mac_tx_ack_i) || state_q == ST_SEND);

    // ------------------------------
    // FSM
    // ------------------------------
    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= ST_IDLE;
            mac_tx_req_o <= 1'b0;
            first_q      <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    first_q <= 1'b1;
                    if (!fifo_empty_i) begin
                        state_q      <= ST_REQ;
                        mac_tx_req_o <= 1'b1;
                    end
                end
                ST_REQ: begin
                    if (fifo_empty_i) begin          // frame flushed before the ack
                        state_q      <= ST_IDLE;
                        mac_tx_req_o <= 1'b0;
                    end else if (mac_tx_ack_i) begin
                        mac_tx_req_o <= 1'b0;
                        state_q      <= fifo_beat_i.last ? ST_IDLE : ST_SEND;
                    end
                end
                ST_SEND: begin
                    // ack is ignored here
                    if (fifo_empty_i || fifo_beat_i.last) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
            if (fifo_pop_o) begin
                first_q <= 1'b0;
            end
        end
    end

    // ------------------------------
    // MAC side
    // ------------------------------
    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mac_tx_valid_o <= 1'b0;
            mac_tx_sof_o   <= 1'b0;
            mac_tx_eof_o   <= 1'b0;
        end else begin
            mac_tx_valid_o <= fifo_pop_o;
            mac_tx_sof_o   <= fifo_pop_o && first_q;
            mac_tx_eof_o   <= fifo_pop_o && fifo_beat_i.last;
        end
    end

    always_ff @(posedge clk125M) begin
        mac_tx_data_o <= fifo_beat_i.data;
    end

endmodule

//--- design/eth_link_bridge.sv
`timescale 1ns/1ps
/*
 * Per-port frame path between up to ETH_COUNT MACs and one serial link.
 * Each port gets a payload cutter, two FIFOs and a transmit sequencer.
 */
module eth_link_bridge
    import eth_bridge_pkg::*;
(
    input  logic                 clk125M,
    input  logic                 rst_n_i,

    // MAC side
    input  byte_t                mac_rx_data_i [ETH_COUNT],
    input  logic [ETH_COUNT-1:0] mac_rx_den_i,
    input  logic [ETH_COUNT-1:0] mac_rx_sof_i,
    input  logic [ETH_COUNT-1:0] mac_rx_eof_i,
    input  logic [ETH_COUNT-1:0] mac_link_i,
    input  logic [ETH_COUNT-1:0] mac_tx_ack_i,
    output logic [ETH_COUNT-1:0] mac_tx_req_o,
    output byte_t                mac_tx_data_o [ETH_COUNT],
    output logic [ETH_COUNT-1:0] mac_tx_valid_o,
    output logic [ETH_COUNT-1:0] mac_tx_sof_o,
    output logic [ETH_COUNT-1:0] mac_tx_eof_o,

    // control
    input  logic                 link_up_i,
    input  logic                 module_en_i,
    input  port_t                eth_sel_i,

    // serial link side
    input  byte_t                link_rx_data_i,
    input  logic                 link_rx_valid_i,
    input  logic                 link_rx_last_i,
    input  logic                 link_tx_ready_i,
    output byte_t                link_tx_data_o,
    output logic                 link_tx_valid_o,
    output logic                 link_tx_last_o
);

    rx_beat_t             cut_beat [ETH_COUNT];
    logic [ETH_COUNT-1:0] cut_valid;
    logic [ETH_COUNT-1:0] cut_sof;      // payload start marks
    rx_beat_t             rx_head  [ETH_COUNT];
    logic [ETH_COUNT-1:0] rx_empty;
    logic [ETH_COUNT-1:0] rx_pop;
    tx_beat_t             tx_head  [ETH_COUNT];
    logic [ETH_COUNT-1:0] tx_empty;
    logic [ETH_COUNT-1:0] tx_pop;
    logic [ETH_COUNT-1:0] tx_wr;
    logic [ETH_COUNT-1:0] flush;
    tx_beat_t             link_rx_beat;  // fanned out to every transmit FIFO

    // ------------------------------
    // port selection
    // ------------------------------
    link_port_select i_link_port_select (
        .clk125M         (clk125M),
        .rst_n_i         (rst_n_i),
        .module_en_i     (module_en_i),
        .eth_sel_i       (eth_sel_i),
        .mac_link_i      (mac_link_i),
        .link_up_i       (link_up_i),
        .rx_beat_i       (rx_head),
        .rx_empty_i      (rx_empty),
        .link_rx_data_i  (link_rx_data_i),
        .link_rx_valid_i (link_rx_valid_i),
        .link_rx_last_i  (link_rx_last_i),
        .link_tx_ready_i (link_tx_ready_i),
        .flush_o         (flush),
        .rx_pop_o        (rx_pop),
        .tx_wr_o         (tx_wr),
        .tx_beat_o       (link_rx_beat),
        .link_tx_data_o  (link_tx_data_o),
        .link_tx_valid_o (link_tx_valid_o),
        .link_tx_last_o  (link_tx_last_o)
    );

    // ------------------------------
    // per port
    // ------------------------------
    for (genvar x = 0; x < ETH_COUNT; x++) begin : g_port

        rx_payload_cut i_rx_payload_cut (
            .clk125M     (clk125M),
            .rst_n_i     (rst_n_i),
            .rx_data_i   (mac_rx_data_i[x]),
            .rx_den_i    (mac_rx_den_i[x]),
            .rx_sof_i    (mac_rx_sof_i[x]),
            .rx_eof_i    (mac_rx_eof_i[x]),
            .cut_beat_o  (cut_beat[x]),
            .cut_valid_o (cut_valid[x]),
            .cut_sof_o   (cut_sof[x])
        );

        // MAC -> link
        frame_fifo #(
            .beat_t (rx_beat_t)
        ) i_rx_fifo (
            .clk125M   (clk125M),
            .rst_n_i   (rst_n_i),
            .flush_i   (flush[x]),
            .wr_i      (cut_valid[x]),
            .wr_beat_i (cut_beat[x]),
            .pop_i     (rx_pop[x]),
            .rd_beat_o (rx_head[x]),
            .empty_o   (rx_empty[x])
        );

        // link -> MAC
        frame_fifo #(
            .beat_t (tx_beat_t)
        ) i_tx_fifo (
            .clk125M   (clk125M),
            .rst_n_i   (rst_n_i),
            .flush_i   (flush[x]),
            .wr_i      (tx_wr[x]),
            .wr_beat_i (link_rx_beat),
            .pop_i     (tx_pop[x]),
            .rd_beat_o (tx_head[x]),
            .empty_o   (tx_empty[x])
        );

        mac_tx_sequencer i_mac_tx_sequencer (
            .clk125M        (clk125M),
            .rst_n_i        (rst_n_i),
            .fifo_beat_i    (tx_head[x]),
            .fifo_empty_i   (tx_empty[x]),
            .mac_tx_ack_i   (mac_tx_ack_i[x]),
            .fifo_pop_o     (tx_pop[x]),
            .mac_tx_req_o   (mac_tx_req_o[x]),
            .mac_tx_data_o  (mac_tx_data_o[x]),
            .mac_tx_valid_o (mac_tx_valid_o[x]),
            .mac_tx_sof_o   (mac_tx_sof_o[x]),
            .mac_tx_eof_o   (mac_tx_eof_o[x])
        );

    end

endmodule

//--- sim/eth_link_bridge_checker.sv
`timescale 1ns/1ps
/*
 * Link, MAC transmit and payload framing assertions, bound onto the bridge top level.
 */
module eth_link_bridge_checker
    import eth_bridge_pkg::*;
(
    input logic                 clk125M,
    input logic                 rst_n_i,
    input byte_t                link_tx_data_o,
    input logic                 link_tx_valid_o,
    input logic                 link_tx_last_o,
    input logic                 link_tx_ready_i,
    input logic [ETH_COUNT-1:0] mac_tx_ack_i,
    input logic [ETH_COUNT-1:0] mac_tx_valid_o,
    input logic [ETH_COUNT-1:0] mac_tx_sof_o,
    input logic [ETH_COUNT-1:0] mac_tx_eof_o,
    input rx_beat_t             cut_beat_i [ETH_COUNT],
    input logic [ETH_COUNT-1:0] cut_valid_i,
    input logic [ETH_COUNT-1:0] cut_sof_i
);

    int                   assert_fails = 0;   // failed assertions so far
    logic [ETH_COUNT-1:0] open_q;             // payload started, last not seen yet

    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            open_q <= '0;
        end else begin
            for (int x = 0; x < ETH_COUNT; x++) begin
                if (cut_valid_i[x]) begin
                    open_q[x] <= !cut_beat_i[x].last;
                end
            end
        end
    end

    // stalled link beat must hold
    link_hold: assert property (@(posedge clk125M) disable iff (!rst_n_i)
        (link_tx_valid_o && !link_tx_ready_i) |=>
            (link_tx_valid_o && $stable(link_tx_data_o) && $stable(link_tx_last_o)))
        else begin
            $error("link transmit beat changed while ready was low");
            assert_fails++;
        end

    // ------------------------------
    // per MAC port
    // ------------------------------
    for (genvar x = 0; x < ETH_COUNT; x++) begin : g_port
        // start mark exactly on the first payload beat of a frame
        payload_start: assert property (@(posedge clk125M) disable iff (!rst_n_i)
            cut_valid_i[x] |-> (cut_sof_i[x] == !open_q[x]))
            else begin
                $error("payload start mark out of place on port %0d", x);
                assert_fails++;
            end

        sof_on_first: assert property (@(posedge clk125M) disable iff (!rst_n_i)
            mac_tx_sof_o[x] == $rose(mac_tx_valid_o[x]))
            else begin
                $error("mac sof not on the first valid beat on port %0d", x);
                assert_fails++;
            end

        // valid drops right after eof and only then
        eof_on_last: assert property (@(posedge clk125M) disable iff (!rst_n_i)
            $fell(mac_tx_valid_o[x]) == $past(mac_tx_eof_o[x]))
            else begin
                $error("mac frame did not end on its eof beat on port %0d", x);
                assert_fails++;
            end

        valid_after_ack: assert property (@(posedge clk125M) disable iff (!rst_n_i)
            $rose(mac_tx_valid_o[x]) |-> $past(mac_tx_ack_i[x]))
            else begin
                $error("mac valid rose without an ack on port %0d", x);
                assert_fails++;
            end
    end

endmodule

bind eth_link_bridge eth_link_bridge_checker i_eth_link_bridge_checker (
    .clk125M         (clk125M),
    .rst_n_i         (rst_n_i),
    .link_tx_data_o  (link_tx_data_o),
    .link_tx_valid_o (link_tx_valid_o),
    .link_tx_last_o  (link_tx_last_o),
    .link_tx_ready_i (link_tx_ready_i),
    .mac_tx_ack_i    (mac_tx_ack_i),
    .mac_tx_valid_o  (mac_tx_valid_o),
    .mac_tx_sof_o    (mac_tx_sof_o),
    .mac_tx_eof_o    (mac_tx_eof_o),
    .cut_beat_i      (cut_beat),
    .cut_valid_i     (cut_valid),
    .cut_sof_i       (cut_sof)
);

//--- sim/tb_eth_link_bridge.sv
`timescale 1ns/1ps
/*
 * Table-driven testbench for the bridge: frames enter from a MAC or the link and
 * the outputs are compared with the header cut and port selection rules.
 */
module tb_eth_link_bridge
    import eth_bridge_pkg::*;
();

    localparam int ROWS    = 10;
    localparam int SETTLE  = 4;     // flush release after a selection change
    localparam int TIMEOUT = 500;
    localparam int QUIET   = 40;    // window for unexpected extra beats
    localparam int ACK_MIN = 24;    // longer than any link frame in the table

    typedef struct {
        string name;
        bit    en;
        int    sel;
        int    port;
        bit    from_link;   // 0 = MAC receive, 1 = link receive
        int    len;
        int    first;
        int    frames;
        bit    phy_up;
        int    exp_cnt;
    } row_t;

    row_t table_rows [ROWS];

    logic                 clk125M;
    logic                 rst_n         = 1'b0;
    byte_t                mac_rx_data [ETH_COUNT] = '{default: '0};
    logic [ETH_COUNT-1:0] mac_rx_den    = '0;
    logic [ETH_COUNT-1:0] mac_rx_sof    = '0;
    logic [ETH_COUNT-1:0] mac_rx_eof    = '0;
    logic [ETH_COUNT-1:0] mac_link      = '1;
    logic [ETH_COUNT-1:0] mac_tx_ack    = '0;
    logic                 link_up       = 1'b1;
    logic                 module_en     = 1'b0;
    port_t                eth_sel       = '0;
    byte_t                link_rx_data  = '0;
    logic                 link_rx_valid = 1'b0;
    logic                 link_rx_last  = 1'b0;
    logic                 link_tx_ready = 1'b0;
    logic [ETH_COUNT-1:0] mac_tx_req;
    byte_t                mac_tx_data [ETH_COUNT];
    logic [ETH_COUNT-1:0] mac_tx_valid;
    logic [ETH_COUNT-1:0] mac_tx_sof;
    logic [ETH_COUNT-1:0] mac_tx_eof;
    byte_t                link_tx_data;
    logic                 link_tx_valid;
    logic                 link_tx_last;

    integer               seed = 32'hd05e52e9;
    logic [31:0]          rnd;
    int                   ack_cnt [ETH_COUNT];
    int                   cyc;
    int                   errors;
    int                   checks;
    int                   afails;
    logic [ETH_COUNT-1:0] req_seen;
    logic [8:0]           exp_q [$];       // {last, data}
    logic [8:0]           link_q [$];
    logic [12:0]          mac_q [$];       // {req, sof, eof, port, data}
    int                   mac_cyc_q [$];

    eth_link_bridge i_eth_link_bridge (
        .clk125M (clk125M),              .rst_n_i (rst_n),
        .mac_rx_data_i (mac_rx_data),    .mac_rx_den_i (mac_rx_den),
        .mac_rx_sof_i (mac_rx_sof),      .mac_rx_eof_i (mac_rx_eof),
        .mac_link_i (mac_link),          .mac_tx_ack_i (mac_tx_ack),
        .mac_tx_req_o (mac_tx_req),      .mac_tx_data_o (mac_tx_data),
        .mac_tx_valid_o (mac_tx_valid),  .mac_tx_sof_o (mac_tx_sof),
        .mac_tx_eof_o (mac_tx_eof),      .link_up_i (link_up),
        .module_en_i (module_en),        .eth_sel_i (eth_sel),
        .link_rx_data_i (link_rx_data),  .link_rx_valid_i (link_rx_valid),
        .link_rx_last_i (link_rx_last),  .link_tx_ready_i (link_tx_ready),
        .link_tx_data_o (link_tx_data),  .link_tx_valid_o (link_tx_valid),
        .link_tx_last_o (link_tx_last)
    );

    initial begin
        clk125M = 1'b0;
        forever #4 clk125M = ~clk125M;
    end

    // ------------------------------
    // link ready and MAC ack model
    // ------------------------------
    always @(posedge clk125M) begin
        rnd = $random(seed);
        link_tx_ready <= (rnd[1:0] != 2'b00);   // ready about 3 cycles in 4
        for (int x = 0; x < ETH_COUNT; x++) begin
            if (mac_tx_ack[x]) begin
                mac_tx_ack[x] <= 1'b0;           // one-cycle ack
            end else if (ack_cnt[x] > 0) begin
                ack_cnt[x] = ack_cnt[x] - 1;
                if (ack_cnt[x] == 0) begin
                    mac_tx_ack[x] <= 1'b1;
                end
            end else if (mac_tx_req[x]) begin
                ack_cnt[x] = ACK_MIN + int'(rnd[5:2]);
            end
        end
    end

    // output monitor, half a cycle away from the drive edge
    always @(negedge clk125M) begin
        cyc++;
        req_seen = req_seen | mac_tx_req;
        if (link_tx_valid && link_tx_ready) begin
            link_q.push_back({link_tx_last, link_tx_data});
        end
        for (int x = 0; x < ETH_COUNT; x++) begin
            if (mac_tx_valid[x]) begin
                mac_q.push_back({mac_tx_req[x], mac_tx_sof[x], mac_tx_eof[x], 2'(x),
                                 mac_tx_data[x]});
                mac_cyc_q.push_back(cyc);
            end
        end
    end

    function automatic void fill_table();
        //                name             en    sel port link  len first  frm phy   exp
        table_rows[0] = '{"sel_p0_frame",  1'b1, 0, 0, 1'b0, 20, 'h10, 1, 1'b1, 12};
        table_rows[1] = '{"sel_p3_min",    1'b1, 3, 3, 1'b0,  9, 'h40, 1, 1'b1,  1};
        table_rows[2] = '{"unsel_port",    1'b1, 1, 2, 1'b0, 20, 'h20, 1, 1'b1,  0};
        table_rows[3] = '{"module_off",    1'b0, 2, 2, 1'b0, 20, 'h30, 1, 1'b1,  0};
        table_rows[4] = '{"phy_down",      1'b1, 1, 1, 1'b0, 20, 'h50, 1, 1'b0,  0};
        table_rows[5] = '{"short_eq_cut",  1'b1, 1, 1, 1'b0,  8, 'h60, 1, 1'b1,  0};
        table_rows[6] = '{"short_five",    1'b1, 2, 2, 1'b0,  5, 'h70, 1, 1'b1,  0};
        table_rows[7] = '{"link_to_p2",    1'b1, 2, 2, 1'b1, 12, 'h80, 1, 1'b1, 12};
        table_rows[8] = '{"link_one_byte", 1'b1, 0, 0, 1'b1,  1, 'h90, 1, 1'b1,  1};
        table_rows[9] = '{"burst_p1",      1'b1, 1, 1, 1'b0, 20, 'ha0, 3, 1'b1, 36};
    endfunction

    // bytes count up from first across all frames, the first skip of each are dropped
    function automatic void build_expected(input int skip, input int len, input int first,
                                           input int frames);
        int n;
        n = 0;
        for (int f = 0; f < frames; f++) begin
            for (int i = 0; i < len; i++) begin
                if (i >= skip) begin
                    exp_q.push_back({i == len - 1, byte_t'(first + n)});
                end
                n++;
            end
        end
    endfunction

    task automatic report_mismatch(input string name, input string what, input int exp,
                                   input int act);
        errors++;
        $display("Error: %s %s expected 0x%0h actual 0x%0h", name, what, exp, act);
    endtask

    task automatic send_mac_frames(input int port, input int len, input int first,
                                   input int frames);
        int n;
        n = 0;
        for (int f = 0; f < frames; f++) begin
            for (int i = 0; i < len; i++) begin
                @(posedge clk125M);
                mac_rx_data[port] <= byte_t'(first + n);
                mac_rx_den[port]  <= 1'b1;
                mac_rx_sof[port]  <= (i == 0);
                mac_rx_eof[port]  <= (i == len - 1);
                n++;
            end
        end
        @(posedge clk125M);
        mac_rx_den[port] <= 1'b0;
        mac_rx_sof[port] <= 1'b0;
        mac_rx_eof[port] <= 1'b0;
    endtask

    task automatic send_link_frame(input int len, input int first);
        for (int i = 0; i < len; i++) begin
            @(posedge clk125M);
            link_rx_data  <= byte_t'(first + i);
            link_rx_valid <= 1'b1;
            link_rx_last  <= (i == len - 1);
        end
        @(posedge clk125M);
        link_rx_valid <= 1'b0;
        link_rx_last  <= 1'b0;
    endtask

    task automatic compare_link_beats(input row_t rw);
        checks++;
        if (link_q.size() != rw.exp_cnt) begin
            report_mismatch(rw.name, "link beat count", rw.exp_cnt, link_q.size());
        end
        for (int k = 0; k < link_q.size() && k < exp_q.size(); k++) begin
            checks++;
            if (link_q[k] !== exp_q[k]) begin
                report_mismatch(rw.name, $sformatf("link beat %0d {last,data}", k),
                                int'(exp_q[k]), int'(link_q[k]));
            end
        end
    endtask

    task automatic compare_mac_beats(input row_t rw);
        logic [ETH_COUNT-1:0] want_req;
        logic [12:0]          g;
        want_req = '0;
        want_req[rw.port] = 1'b1;
        checks += 2;
        if (mac_q.size() != rw.exp_cnt) begin
            report_mismatch(rw.name, "mac beat count", rw.exp_cnt, mac_q.size());
        end
        if (req_seen !== want_req) begin
            report_mismatch(rw.name, "ports with req", int'(want_req), int'(req_seen));
        end
        for (int k = 0; k < mac_q.size() && k < exp_q.size(); k++) begin
            g = mac_q[k];
            checks++;
            if (g[7:0] !== exp_q[k][7:0]) begin
                report_mismatch(rw.name, $sformatf("mac byte %0d", k),
                                int'(exp_q[k][7:0]), int'(g[7:0]));
            end
            if (g[9:8] != 2'(rw.port)) begin
                report_mismatch(rw.name, $sformatf("mac port of beat %0d", k),
                                rw.port, int'(g[9:8]));
            end
            if (g[10] !== exp_q[k][8] || g[11] !== (k == 0) || g[12] !== 1'b0) begin
                report_mismatch(rw.name, $sformatf("mac {req,sof,eof} of beat %0d", k),
                                int'({1'b0, k == 0, exp_q[k][8]}), int'(g[12:10]));
            end
            if (k > 0 && mac_cyc_q[k] != mac_cyc_q[k-1] + 1) begin
                report_mismatch(rw.name, $sformatf("mac cycle of beat %0d", k),
                                mac_cyc_q[k-1] + 1, mac_cyc_q[k]);
            end
        end
    endtask

    task automatic run_row(input row_t rw);
        logic [ETH_COUNT-1:0] links;
        int                   t;
        links = '1;
        links[rw.port] = rw.phy_up;
        @(posedge clk125M);
        module_en <= rw.en;
        eth_sel   <= port_t'(rw.sel);
        mac_link  <= links;
        repeat (SETTLE) @(posedge clk125M);
        link_q.delete();
        mac_q.delete();
        mac_cyc_q.delete();
        exp_q.delete();
        req_seen = '0;
        if (rw.from_link) begin
            build_expected(0, rw.len, rw.first, 1);
            send_link_frame(rw.len, rw.first);
        end else begin
            build_expected(CUT_BYTES, rw.len, rw.first, rw.frames);
            send_mac_frames(rw.port, rw.len, rw.first, rw.frames);
        end
        t = 0;
        while ((rw.from_link ? mac_q.size() : link_q.size()) < rw.exp_cnt && t < TIMEOUT) begin
            @(posedge clk125M);
            t++;
        end
        if (t >= TIMEOUT) begin
            errors++;
            $display("Error: %s gave too few beats within %0d cycles", rw.name, TIMEOUT);
        end
        repeat (QUIET) @(posedge clk125M);
        if (rw.from_link) begin
            compare_mac_beats(rw);
        end else begin
            compare_link_beats(rw);
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        fill_table();
        repeat (10) @(posedge clk125M);
        rst_n <= 1'b1;
        repeat (SETTLE) @(posedge clk125M);
        for (int r = 0; r < ROWS; r++) begin
            run_row(table_rows[r]);
        end
        afails = i_eth_link_bridge.i_eth_link_bridge_checker.assert_fails;
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, afails);
        if (errors == 0 && afails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- sources.f
design/eth_bridge_pkg.sv
design/rx_payload_cut.sv
design/frame_fifo.sv
design/link_port_select.sv
design/mac_tx_sequencer.sv
design/eth_link_bridge.sv
sim/eth_link_bridge_checker.sv
sim/tb_eth_link_bridge.sv

//--- Makefile
# Verilator build and run for the Ethernet to serial link bridge testbench
# e.g. make run TOP=tb_eth_link_bridge LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_eth_link_bridge
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := Done: no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
